// ==== design/alloc_pkg.sv ====
package alloc_pkg;

    localparam int NUM_VC   = 4;            // vcs per port
    localparam int NUM_PORT = 5;            // router ports
    localparam int NUM_DEST = NUM_PORT - 1; // no port sends to itself

    typedef logic [NUM_VC-1:0]   vc_vec_t;
    typedef logic [NUM_DEST-1:0] dest_vec_t;

    // one input vc as seen by the allocator
    typedef struct packed {
        logic      request;
        logic      ovc_is_assigned;
        logic      assigned_ovc_not_full;
        vc_vec_t   free_ovc_mask;           // already masked upstream
        dest_vec_t dest;
    } ivc_req_t;

    typedef ivc_req_t [NUM_VC-1:0] port_req_t;

    typedef struct packed {
        vc_vec_t   sw_granted_ivc;
        vc_vec_t   ovc_granted_ivc;
        vc_vec_t   granted_ovc;
        dest_vec_t granted_dest;
        logic      any_ivc_granted;
    } in_grant_t;

    typedef struct packed {
        vc_vec_t ovc_allocated;
        logic    any_ovc_granted;
    } out_grant_t;

    typedef struct packed {
        vc_vec_t   first_grant;             // input arbiter pick, ungated
        dest_vec_t granted_dest;
        logic      any_ivc_granted;
    } sw_state_t;

    // bit of self_port's dest vector that stands for other_port
    function automatic int dest_bit(input int self_port, input int other_port);
        return (other_port < self_port) ? other_port : other_port - 1;
    endfunction

endpackage

// ==== design/rr_arbiter.sv ====
`timescale 1ns/10ps

module rr_arbiter #(
    parameter int WIDTH = 4
) (
    input  logic             clk,
    input  logic             rst_n,
    input  logic [WIDTH-1:0] request,
    input  logic             update_en,
    output logic [WIDTH-1:0] grant,
    output logic             any_grant
);

    logic [$clog2(WIDTH)-1:0] ptr;       // index with highest priority
    logic [$clog2(WIDTH)-1:0] win_idx;
    logic [$clog2(WIDTH)-1:0] next_ptr;

    // first requester at or after ptr, circular search
    always_comb begin
        int   idx;
        logic found;
        grant   = '0;
        win_idx = '0;
        found   = 1'b0;
        for (int k = 0; k < WIDTH; k++) begin
            idx = int'(ptr) + k;
            if (idx >= WIDTH) begin
                idx = idx - WIDTH;       // wrap around
            end
            if (!found && request[idx]) begin
                grant[idx] = 1'b1;
                win_idx    = idx[$clog2(WIDTH)-1:0];
                found      = 1'b1;
            end
        end
    end

    assign any_grant = |request;

    // winner drops to lowest priority
    assign next_ptr = (int'(win_idx) == WIDTH - 1) ? '0 : win_idx + 1'b1;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            ptr <= '0;
        end else if (update_en && any_grant) begin
            ptr <= next_ptr;
        end
    end

endmodule

// ==== design/vc_request_decode.sv ====
`timescale 1ns/10ps

module vc_request_decode (
    input  logic                 clk,
    input  logic                 rst_n,
    input  alloc_pkg::port_req_t port_req      [alloc_pkg::NUM_PORT],
    output alloc_pkg::vc_vec_t   competing     [alloc_pkg::NUM_PORT],
    output alloc_pkg::vc_vec_t   candidate_ovc [alloc_pkg::NUM_PORT][alloc_pkg::NUM_VC]
);

    // any_grant of each candidate arbiter, fed back as its update enable
    logic [alloc_pkg::NUM_VC-1:0] cand_found [alloc_pkg::NUM_PORT];

    genvar p, v;
    generate
        for (p = 0; p < alloc_pkg::NUM_PORT; p++) begin : g_port
            for (v = 0; v < alloc_pkg::NUM_VC; v++) begin : g_vc
                alloc_pkg::ivc_req_t req;
                logic                free_req;   // wants a new ovc and one is free
                logic                held_req;   // already owns an ovc with room

                assign req = port_req[p][v];

                assign free_req = !req.ovc_is_assigned && (|req.free_ovc_mask);
                assign held_req = req.request && req.ovc_is_assigned
                                  && req.assigned_ovc_not_full;

                assign competing[p][v] = free_req | held_req;

                // picks one candidate ovc out of the free ones
                rr_arbiter #(
                    .WIDTH     (alloc_pkg::NUM_VC)
                ) u_cand_arb (
                    .clk       (clk),
                    .rst_n     (rst_n),
                    .request   (req.free_ovc_mask),
                    .update_en (cand_found[p][v]),
                    .grant     (candidate_ovc[p][v]),
                    .any_grant (cand_found[p][v])
                );
            end
        end
    endgenerate

endmodule

// ==== design/sw_alloc_execute.sv ====
`timescale 1ns/10ps

module sw_alloc_execute (
    input  logic                           clk,
    input  logic                           rst_n,
    input  alloc_pkg::vc_vec_t             competing [alloc_pkg::NUM_PORT],
    input  alloc_pkg::port_req_t           port_req  [alloc_pkg::NUM_PORT],
    output alloc_pkg::sw_state_t           sw_state  [alloc_pkg::NUM_PORT],
    output logic [alloc_pkg::NUM_PORT-1:0] any_ovc_granted
);

    alloc_pkg::vc_vec_t           first_grant  [alloc_pkg::NUM_PORT]; // stage 1 picks
    alloc_pkg::dest_vec_t         sel_dest     [alloc_pkg::NUM_PORT]; // dest of the pick
    alloc_pkg::dest_vec_t         out_req      [alloc_pkg::NUM_PORT]; // per output port
    alloc_pkg::dest_vec_t         out_grant    [alloc_pkg::NUM_PORT];
    alloc_pkg::dest_vec_t         granted_dest [alloc_pkg::NUM_PORT]; // back at input side
    logic [alloc_pkg::NUM_PORT-1:0] any_ivc_granted;

    // dest of the picked vc, one-hot mux
    always_comb begin
        for (int i = 0; i < alloc_pkg::NUM_PORT; i++) begin
            sel_dest[i] = '0;
            for (int v = 0; v < alloc_pkg::NUM_VC; v++) begin
                sel_dest[i] |= port_req[i][v].dest
                               & {alloc_pkg::NUM_DEST{first_grant[i][v]}};
            end
        end
    end

    // input port i shows up at output o on bit dest_bit(o, i)
    always_comb begin
        for (int o = 0; o < alloc_pkg::NUM_PORT; o++) begin
            out_req[o] = '0;
            for (int i = 0; i < alloc_pkg::NUM_PORT; i++) begin
                if (i != o) begin
                    out_req[o][alloc_pkg::dest_bit(o, i)] =
                        sel_dest[i][alloc_pkg::dest_bit(i, o)];
                end
            end
        end
    end

    // same map read the other way for the grants
    always_comb begin
        for (int i = 0; i < alloc_pkg::NUM_PORT; i++) begin
            granted_dest[i] = '0;
            for (int o = 0; o < alloc_pkg::NUM_PORT; o++) begin
                if (o != i) begin
                    granted_dest[i][alloc_pkg::dest_bit(i, o)] =
                        out_grant[o][alloc_pkg::dest_bit(o, i)];
                end
            end
        end
    end

    genvar i;
    generate
        for (i = 0; i < alloc_pkg::NUM_PORT; i++) begin : g_port
            // input arbiter moves only when its port wins
            rr_arbiter #(
                .WIDTH     (alloc_pkg::NUM_VC)
            ) u_in_arb (
                .clk       (clk),
                .rst_n     (rst_n),
                .request   (competing[i]),
                .update_en (any_ivc_granted[i]),
                .grant     (first_grant[i]),
                .any_grant ()
            );

            rr_arbiter #(
                .WIDTH     (alloc_pkg::NUM_DEST)
            ) u_out_arb (
                .clk       (clk),
                .rst_n     (rst_n),
                .request   (out_req[i]),
                .update_en (any_ovc_granted[i]),
                .grant     (out_grant[i]),
                .any_grant (any_ovc_granted[i])
            );

            assign any_ivc_granted[i] = |granted_dest[i];

            assign sw_state[i].first_grant     = first_grant[i];
            assign sw_state[i].granted_dest    = granted_dest[i];
            assign sw_state[i].any_ivc_granted = any_ivc_granted[i];
        end
    endgenerate

endmodule

// ==== design/grant_result.sv ====
`timescale 1ns/10ps

module grant_result (
    input  alloc_pkg::vc_vec_t    candidate_ovc [alloc_pkg::NUM_PORT][alloc_pkg::NUM_VC],
    input  alloc_pkg::sw_state_t  sw_state      [alloc_pkg::NUM_PORT],
    output alloc_pkg::in_grant_t  in_grant      [alloc_pkg::NUM_PORT],
    output alloc_pkg::vc_vec_t    ovc_allocated [alloc_pkg::NUM_PORT]
);

    alloc_pkg::vc_vec_t cand_sel   [alloc_pkg::NUM_PORT];  // candidate of the first pick
    alloc_pkg::vc_vec_t cand_gated [alloc_pkg::NUM_PORT];  // zero unless port won
    logic [alloc_pkg::NUM_PORT-1:0] has_cand;
    // candidate spread onto the granted dest bit
    alloc_pkg::vc_vec_t cand_to_dest [alloc_pkg::NUM_PORT][alloc_pkg::NUM_DEST];

    always_comb begin
        for (int i = 0; i < alloc_pkg::NUM_PORT; i++) begin
            cand_sel[i] = '0;
            for (int v = 0; v < alloc_pkg::NUM_VC; v++) begin
                cand_sel[i] |= candidate_ovc[i][v]
                               & {alloc_pkg::NUM_VC{sw_state[i].first_grant[v]}};
            end
            has_cand[i]   = |cand_sel[i];
            cand_gated[i] = sw_state[i].any_ivc_granted ? cand_sel[i] : '0;
        end
    end

    // one-hot demux by granted_dest
    always_comb begin
        for (int i = 0; i < alloc_pkg::NUM_PORT; i++) begin
            for (int d = 0; d < alloc_pkg::NUM_DEST; d++) begin
                cand_to_dest[i][d] = sw_state[i].granted_dest[d] ? cand_sel[i] : '0;
            end
        end
    end

    // at most one input wins an output, OR is enough
    always_comb begin
        for (int o = 0; o < alloc_pkg::NUM_PORT; o++) begin
            ovc_allocated[o] = '0;
            for (int i = 0; i < alloc_pkg::NUM_PORT; i++) begin
                if (i != o) begin
                    ovc_allocated[o] |= cand_to_dest[i][alloc_pkg::dest_bit(i, o)];
                end
            end
        end
    end

    always_comb begin
        for (int i = 0; i < alloc_pkg::NUM_PORT; i++) begin
            in_grant[i].sw_granted_ivc  = sw_state[i].any_ivc_granted
                                          ? sw_state[i].first_grant : '0;
            // an assigned vc wins the switch but takes no new ovc
            in_grant[i].ovc_granted_ivc = (sw_state[i].any_ivc_granted && has_cand[i])
                                          ? sw_state[i].first_grant : '0;
            in_grant[i].granted_ovc     = cand_gated[i];
            in_grant[i].granted_dest    = sw_state[i].granted_dest;
            in_grant[i].any_ivc_granted = sw_state[i].any_ivc_granted;
        end
    end

endmodule

// ==== design/comb_nonspec_alloc.sv ====
`timescale 1ns/10ps

module comb_nonspec_alloc (
    input  logic                  clk,
    input  logic                  rst_n,
    input  alloc_pkg::port_req_t  port_req  [alloc_pkg::NUM_PORT],
    output alloc_pkg::in_grant_t  in_grant  [alloc_pkg::NUM_PORT],
    output alloc_pkg::out_grant_t out_grant [alloc_pkg::NUM_PORT]
);

    alloc_pkg::vc_vec_t   competing     [alloc_pkg::NUM_PORT];
    alloc_pkg::vc_vec_t   candidate_ovc [alloc_pkg::NUM_PORT][alloc_pkg::NUM_VC];
    alloc_pkg::sw_state_t sw_state      [alloc_pkg::NUM_PORT];
    alloc_pkg::vc_vec_t   ovc_allocated [alloc_pkg::NUM_PORT];
    logic [alloc_pkg::NUM_PORT-1:0] any_ovc_granted;

    // masking and candidate ovc choice
    vc_request_decode decode (
        .clk           (clk),
        .rst_n         (rst_n),
        .port_req      (port_req),
        .competing     (competing),
        .candidate_ovc (candidate_ovc)
    );

    // two stage switch allocation
    sw_alloc_execute execute (
        .clk             (clk),
        .rst_n           (rst_n),
        .competing       (competing),
        .port_req        (port_req),
        .sw_state        (sw_state),
        .any_ovc_granted (any_ovc_granted)
    );

    grant_result result (
        .candidate_ovc (candidate_ovc),
        .sw_state      (sw_state),
        .in_grant      (in_grant),
        .ovc_allocated (ovc_allocated)
    );

    // output port side bundle
    genvar o;
    generate
        for (o = 0; o < alloc_pkg::NUM_PORT; o++) begin : g_out
            assign out_grant[o].ovc_allocated   = ovc_allocated[o];
            assign out_grant[o].any_ovc_granted = any_ovc_granted[o];
        end
    endgenerate

endmodule

// ==== bench/alloc_clock_gen.sv ====
`timescale 1ns/10ps

module alloc_clock_gen #(
    parameter int PERIOD_NS    = 100,
    parameter int RESET_CYCLES = 3
) (
    output logic clk,
    output logic rst_n
);

    initial begin
        clk = 1'b0;
        forever #(PERIOD_NS / 2) clk = ~clk;
    end

    initial begin
        rst_n = 1'b0;
        repeat (RESET_CYCLES) @(posedge clk);
        rst_n <= 1'b1;              // released right on a rising edge
    end

endmodule

// ==== bench/alloc_tb.sv ====
`timescale 1ns/10ps

module alloc_tb;

    localparam int RESET_TIMEOUT = 10;
    localparam int RANDOM_CYCLES = 200;

    logic                  clk;
    logic                  rst_n;
    alloc_pkg::port_req_t  port_req  [alloc_pkg::NUM_PORT];
    alloc_pkg::in_grant_t  in_grant  [alloc_pkg::NUM_PORT];
    alloc_pkg::out_grant_t out_grant [alloc_pkg::NUM_PORT];

    // reference model pointers and the picks of the current cycle
    int cand_ptr  [alloc_pkg::NUM_PORT][alloc_pkg::NUM_VC];
    int in_ptr    [alloc_pkg::NUM_PORT];
    int out_ptr   [alloc_pkg::NUM_PORT];
    int cand_pick [alloc_pkg::NUM_PORT][alloc_pkg::NUM_VC];
    int in_pick   [alloc_pkg::NUM_PORT];
    int out_pick  [alloc_pkg::NUM_PORT];
    alloc_pkg::in_grant_t  exp_in  [alloc_pkg::NUM_PORT];
    alloc_pkg::out_grant_t exp_out [alloc_pkg::NUM_PORT];

    int error_count;
    int seed;

    alloc_clock_gen #(
        .PERIOD_NS    (100),
        .RESET_CYCLES (3)
    ) clock_gen (
        .clk   (clk),
        .rst_n (rst_n)
    );

    comb_nonspec_alloc uut (
        .clk       (clk),
        .rst_n     (rst_n),
        .port_req  (port_req),
        .in_grant  (in_grant),
        .out_grant (out_grant)
    );

    task automatic check_value(input string name, input logic [31:0] actual,
                               input logic [31:0] expected);
        if (actual !== expected) begin
            error_count++;
            $display("** Error at time %0t: %s is %h, expected %h",
                     $time, name, actual, expected);
            $display("FAIL: see errors above");
            $fatal(1, "stopping at first mismatch");
        end
    endtask

    // circular search from ptr, -1 when nothing requests
    function automatic int rr_pick(input logic [31:0] req, input int ptr, input int width);
        int idx;
        for (int k = 0; k < width; k++) begin
            idx = (ptr + k) % width;
            if (req[idx]) begin
                return idx;
            end
        end
        return -1;
    endfunction

    // router port that dest bit b of port self stands for
    function automatic int port_of_bit(input int self, input int b);
        return (b < self) ? b : b + 1;
    endfunction

    function automatic alloc_pkg::ivc_req_t make_free_req(input alloc_pkg::vc_vec_t mask,
                                                          input alloc_pkg::dest_vec_t dest);
        alloc_pkg::ivc_req_t r;
        r               = '0;
        r.request       = 1'b1;
        r.free_ovc_mask = mask;
        r.dest          = dest;
        return r;
    endfunction

    function automatic alloc_pkg::ivc_req_t make_held_req(input alloc_pkg::dest_vec_t dest);
        alloc_pkg::ivc_req_t r;
        r                       = '0;
        r.request               = 1'b1;
        r.ovc_is_assigned       = 1'b1;
        r.assigned_ovc_not_full = 1'b1;
        r.dest                  = dest;
        return r;
    endfunction

    function automatic void reset_model();
        for (int p = 0; p < alloc_pkg::NUM_PORT; p++) begin
            in_ptr[p]  = 0;
            out_ptr[p] = 0;
            for (int v = 0; v < alloc_pkg::NUM_VC; v++) begin
                cand_ptr[p][v] = 0;
            end
        end
    endfunction

    function automatic void predict_grants();
        alloc_pkg::ivc_req_t  r;
        logic [31:0]          comp;
        logic [31:0]          oreq;
        alloc_pkg::dest_vec_t pick_dest [alloc_pkg::NUM_PORT];
        alloc_pkg::vc_vec_t   cand_oh   [alloc_pkg::NUM_PORT];
        int                   src;
        for (int p = 0; p < alloc_pkg::NUM_PORT; p++) begin
            comp = '0;
            for (int v = 0; v < alloc_pkg::NUM_VC; v++) begin
                r = port_req[p][v];
                comp[v] = (!r.ovc_is_assigned && r.free_ovc_mask != 0)
                          || (r.request && r.ovc_is_assigned && r.assigned_ovc_not_full);
                cand_pick[p][v] = rr_pick(32'(r.free_ovc_mask), cand_ptr[p][v],
                                          alloc_pkg::NUM_VC);
            end
            in_pick[p]   = rr_pick(comp, in_ptr[p], alloc_pkg::NUM_VC);
            pick_dest[p] = '0;
            cand_oh[p]   = '0;
            if (in_pick[p] >= 0) begin
                pick_dest[p] = port_req[p][in_pick[p]].dest;
                if (cand_pick[p][in_pick[p]] >= 0) begin
                    cand_oh[p][cand_pick[p][in_pick[p]]] = 1'b1;
                end
            end
            exp_in[p] = '0;
        end
        for (int o = 0; o < alloc_pkg::NUM_PORT; o++) begin
            oreq = '0;
            for (int b = 0; b < alloc_pkg::NUM_DEST; b++) begin
                src = port_of_bit(o, b);
                for (int d = 0; d < alloc_pkg::NUM_DEST; d++) begin
                    if (port_of_bit(src, d) == o && pick_dest[src][d]) begin
                        oreq[b] = 1'b1;
                    end
                end
            end
            out_pick[o] = rr_pick(oreq, out_ptr[o], alloc_pkg::NUM_DEST);
            exp_out[o]  = '0;
            exp_out[o].any_ovc_granted = (oreq != 0);
            if (out_pick[o] >= 0) begin
                src = port_of_bit(o, out_pick[o]);   // winning input port
                exp_out[o].ovc_allocated = cand_oh[src];
                for (int d = 0; d < alloc_pkg::NUM_DEST; d++) begin
                    if (port_of_bit(src, d) == o) begin
                        exp_in[src].granted_dest[d] = 1'b1;
                    end
                end
            end
        end
        for (int p = 0; p < alloc_pkg::NUM_PORT; p++) begin
            if (exp_in[p].granted_dest != 0) begin
                exp_in[p].any_ivc_granted             = 1'b1;
                exp_in[p].sw_granted_ivc[in_pick[p]]  = 1'b1;
                exp_in[p].granted_ovc                 = cand_oh[p];
                if (cand_oh[p] != 0) begin
                    exp_in[p].ovc_granted_ivc[in_pick[p]] = 1'b1;
                end
            end
        end
    endfunction

    // pointer moves taken at the rising edge
    function automatic void advance_model();
        for (int p = 0; p < alloc_pkg::NUM_PORT; p++) begin
            for (int v = 0; v < alloc_pkg::NUM_VC; v++) begin
                if (cand_pick[p][v] >= 0) begin
                    cand_ptr[p][v] = (cand_pick[p][v] + 1) % alloc_pkg::NUM_VC;
                end
            end
            if (exp_in[p].any_ivc_granted) begin
                in_ptr[p] = (in_pick[p] + 1) % alloc_pkg::NUM_VC;
            end
            if (out_pick[p] >= 0) begin
                out_ptr[p] = (out_pick[p] + 1) % alloc_pkg::NUM_DEST;
            end
        end
    endfunction

    task automatic compare_with_model();
        for (int p = 0; p < alloc_pkg::NUM_PORT; p++) begin
            check_value($sformatf("in_grant[%0d].sw_granted_ivc", p),
                        in_grant[p].sw_granted_ivc, exp_in[p].sw_granted_ivc);
            check_value($sformatf("in_grant[%0d].ovc_granted_ivc", p),
                        in_grant[p].ovc_granted_ivc, exp_in[p].ovc_granted_ivc);
            check_value($sformatf("in_grant[%0d].granted_ovc", p),
                        in_grant[p].granted_ovc, exp_in[p].granted_ovc);
            check_value($sformatf("in_grant[%0d].granted_dest", p),
                        in_grant[p].granted_dest, exp_in[p].granted_dest);
            check_value($sformatf("in_grant[%0d].any_ivc_granted", p),
                        in_grant[p].any_ivc_granted, exp_in[p].any_ivc_granted);
            check_value($sformatf("out_grant[%0d].ovc_allocated", p),
                        out_grant[p].ovc_allocated, exp_out[p].ovc_allocated);
            check_value($sformatf("out_grant[%0d].any_ovc_granted", p),
                        out_grant[p].any_ovc_granted, exp_out[p].any_ovc_granted);
        end
    endtask

    // inputs went in 1 ns after the edge, sample 10 ns before the next one
    task automatic settle_and_check();
        predict_grants();
        @(negedge clk);
        #40;
        compare_with_model();
    endtask

    task automatic next_edge();
        @(posedge clk);
        advance_model();
        #1;
    endtask

    task automatic clear_requests();
        for (int p = 0; p < alloc_pkg::NUM_PORT; p++) begin
            port_req[p] = '0;
        end
    endtask

    task automatic wait_reset_release();
        int cycles;
        cycles = 0;
        while (rst_n !== 1'b1) begin
            if (cycles >= RESET_TIMEOUT) begin
                $display("reset was still active after %0d clock cycles", cycles);
                $display("FAIL: see errors above");
                $fatal(1, "reset timeout");
            end
            @(posedge clk);
            #1;
            cycles++;
        end
    endtask

    task automatic idle_no_grants();
        clear_requests();
        for (int k = 0; k < 2; k++) begin
            settle_and_check();
            for (int p = 0; p < alloc_pkg::NUM_PORT; p++) begin
                check_value($sformatf("in_grant[%0d]", p), 32'(in_grant[p]), '0);
                check_value($sformatf("out_grant[%0d]", p), 32'(out_grant[p]), '0);
            end
            next_edge();
        end
    endtask

    task automatic single_free_request();
        clear_requests();
        port_req[1][2] = make_free_req(4'b0110, 4'b0100);   // bit 2 of port 1 is output 3
        settle_and_check();
        check_value("in_grant[1].sw_granted_ivc", in_grant[1].sw_granted_ivc, 4'b0100);
        check_value("in_grant[1].ovc_granted_ivc", in_grant[1].ovc_granted_ivc, 4'b0100);
        check_value("in_grant[1].granted_ovc", in_grant[1].granted_ovc, 4'b0010);
        check_value("in_grant[1].granted_dest", in_grant[1].granted_dest, 4'b0100);
        check_value("out_grant[3].ovc_allocated", out_grant[3].ovc_allocated, 4'b0010);
        check_value("out_grant[3].any_ovc_granted", out_grant[3].any_ovc_granted, 1'b1);
        next_edge();
    endtask

    task automatic assigned_vc_request();
        clear_requests();
        port_req[0][1] = make_held_req(4'b0001);             // output 1
        settle_and_check();
        check_value("in_grant[0].sw_granted_ivc", in_grant[0].sw_granted_ivc, 4'b0010);
        check_value("in_grant[0].ovc_granted_ivc", in_grant[0].ovc_granted_ivc, '0);
        check_value("out_grant[1].ovc_allocated", out_grant[1].ovc_allocated, '0);
        next_edge();
        port_req[0][1].assigned_ovc_not_full = 1'b0;        // downstream vc full
        settle_and_check();
        check_value("in_grant[0].any_ivc_granted", in_grant[0].any_ivc_granted, 1'b0);
        check_value("out_grant[1].any_ovc_granted", out_grant[1].any_ovc_granted, 1'b0);
        next_edge();
    endtask

    task automatic output_contention();
        logic               prev_won0;
        alloc_pkg::vc_vec_t last_vc0;
        clear_requests();
        port_req[0][0] = make_held_req(4'b1000);             // both ports aim at output 4
        port_req[0][1] = make_held_req(4'b1000);
        port_req[2][3] = make_held_req(4'b1000);
        prev_won0 = 1'b0;
        last_vc0  = '0;
        for (int k = 0; k < 6; k++) begin
            settle_and_check();
            check_value("in_grant[0].any_ivc_granted ^ in_grant[2].any_ivc_granted",
                        in_grant[0].any_ivc_granted ^ in_grant[2].any_ivc_granted, 1'b1);
            if (k > 0) begin
                check_value("in_grant[0].any_ivc_granted", in_grant[0].any_ivc_granted,
                            !prev_won0);
            end
            // a lost round must not have moved port 0's input pointer
            if (in_grant[0].any_ivc_granted) begin
                if (last_vc0 != 0) begin
                    check_value("in_grant[0].sw_granted_ivc", in_grant[0].sw_granted_ivc,
                                (last_vc0 == 4'b0001) ? 4'b0010 : 4'b0001);
                end
                last_vc0 = in_grant[0].sw_granted_ivc;
            end
            prev_won0 = in_grant[0].any_ivc_granted;
            next_edge();
        end
    endtask

    task automatic random_traffic();
        int r;
        for (int k = 0; k < RANDOM_CYCLES; k++) begin
            for (int p = 0; p < alloc_pkg::NUM_PORT; p++) begin
                for (int v = 0; v < alloc_pkg::NUM_VC; v++) begin
                    r = $random(seed);
                    port_req[p][v] = '0;
                    if (r[10:9] != 2'b11) begin                 // some vcs stay idle
                        port_req[p][v].request               = r[0];
                        port_req[p][v].ovc_is_assigned       = r[1];
                        port_req[p][v].assigned_ovc_not_full = r[2];
                        port_req[p][v].free_ovc_mask         = r[1] ? 4'b0000 : r[6:3];
                        port_req[p][v].dest                  = 4'b0001 << r[8:7];
                    end
                end
            end
            settle_and_check();
            next_edge();
        end
    endtask

    initial begin
        error_count = 0;
        seed        = 32'hfa2004fd;
        clear_requests();
        reset_model();
        wait_reset_release();
        idle_no_grants();
        single_free_request();
        assigned_vc_request();
        output_contention();
        random_traffic();
        if (error_count == 0) begin
            $display("PASS: all tests");
        end else begin
            $display("FAIL: see errors above");
        end
        $finish;
    end

endmodule

// ==== build.f ====
design/alloc_pkg.sv
design/rr_arbiter.sv
design/vc_request_decode.sv
design/sw_alloc_execute.sv
design/grant_result.sv
design/comb_nonspec_alloc.sv
bench/alloc_clock_gen.sv
bench/alloc_tb.sv

// ==== run.sh ====
#!/bin/sh
# build and run the allocator testbench, verdict taken from the simulator output
cd "$(dirname "$0")" || exit 1
verilator --binary --timing -Wno-fatal -f build.f --top-module alloc_tb -o alloc_sim || exit 1
./obj_dir/alloc_sim | tee /dev/stderr | grep -q "PASS: all tests" \
    && echo "simulation passed" \
    || { echo "simulation failed"; exit 1; }
